// ==== compile.f ====
+incdir+sim
hdl/usb_tx_pkg.sv
hdl/usb_tx_packet_fsm.sv
hdl/usb_tx_crc16.sv
hdl/usb_tx_bit_stuffer.sv
hdl/usb_tx_line_encoder.sv
hdl/usb_tx.sv
sim/tb_usb_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the USB transmitter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_usb_tx -f compile.f

# The simulator exits non-zero on a failure, the search below decides
sim_out=$(./obj_dir/Vtb_usb_tx 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== sim/tb_usb_tx_model.svh ====
// Reference model for the USB transmitter testbench included inside tb_usb_tx
// Uses the DUT signals and the compare tasks of the including module
// Expected bits run from sync through CRC with stuffing, and EOP is checked apart
`ifndef TB_USB_TX_MODEL_SVH
`define TB_USB_TX_MODEL_SVH

logic [31:0] lfsr_q;
logic [7:0]  payload [MAX_PAYLOAD];
logic        exp_bits [$];
int          ones_run;

// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic [31:0] n;
	n = s >> 1;
	if (s[0])
		n = n ^ 32'h8020_0003;
	return n;
endfunction

// One step per bit with the LSB of the byte first
function automatic logic [7:0] lfsr_byte();
	logic [7:0] b;
	for (int i = 0; i < 8; i++) begin
		b[i] = lfsr_q[0];
		lfsr_q = lfsr_next(lfsr_q);
	end
	return b;
endfunction

// Complemented CRC-16 of the payload in reflected form, sent LSB first
function automatic logic [CRC_W-1:0] crc_ref(input int len);
	logic [CRC_W-1:0] poly_r;
	logic [CRC_W-1:0] r;
	for (int i = 0; i < CRC_W; i++)
		poly_r[i] = CRC_POLY[CRC_W-1-i];
	r = CRC_INIT;
	for (int n = 0; n < len; n++) begin
		r = r ^ {8'h00, payload[n]};
		for (int k = 0; k < 8; k++)
			r = r[0] ? ((r >> 1) ^ poly_r) : (r >> 1);
	end
	return ~r;
endfunction

function automatic logic [3:0] pid_for(input logic [PKT_SEL_W-1:0] pkt);
	case (pkt)
		PKT_ACK:   return 4'b0010;
		PKT_NAK:   return 4'b1010;
		PKT_STALL: return 4'b1110;
		default:   return 4'b0011;
	endcase
endfunction

// Zero goes in after six ones in a row
task automatic push_stuffed(input logic b);
	exp_bits.push_back(b);
	if (b)
		ones_run++;
	else
		ones_run = 0;
	if (ones_run == STUFF_LIMIT) begin
		exp_bits.push_back(1'b0);
		ones_run = 0;
	end
endtask

task automatic build_expected(input logic [PKT_SEL_W-1:0] pkt, input int len);
	usb_pid_u         pid;
	logic [CRC_W-1:0] crc;
	exp_bits.delete();
	ones_run = 0;
	for (int i = 0; i < SYNC_BITS; i++)
		exp_bits.push_back((i == SYNC_BITS - 1) ? 1'b1 : 1'b0);
	pid.fields.pid   = pid_for(pkt);
	pid.fields.check = ~pid_for(pkt);
	for (int i = 0; i < 8; i++)
		push_stuffed(pid.raw[i]);
	if (pkt == PKT_DATA0) begin
		for (int n = 0; n < len; n++) begin
			for (int i = 0; i < 8; i++)
				push_stuffed(payload[n][i]);
		end
		crc = crc_ref(len);
		for (int i = 0; i < CRC_W; i++)
			push_stuffed(crc[i]);
	end
endtask

// **************************************************
// Line decoder
// **************************************************
task automatic next_sample(input bit pulse);
	if (pulse) begin
		// Extra start while busy with a different packet select
		@(posedge tb_clk);
		tx_start  <= 1'b1;
		tx_packet <= PKT_STALL;
		@(posedge tb_clk);
		tx_start <= 1'b0;
		repeat (CLKS_PER_BIT - 1) @(negedge tb_clk);
	end else begin
		repeat (CLKS_PER_BIT) @(negedge tb_clk);
	end
endtask

task automatic wait_departure(input string name);
	int waited;
	waited = 0;
	while (dplus === 1'b1 && dminus === 1'b0) begin
		@(negedge tb_clk);
		waited++;
		if (waited > 1)
			report_failure({name, ": line did not leave J one clock after tx_active rose"});
	end
endtask

task automatic decode_packet(input string name, input bit busy_start);
	logic       prev;
	logic       exp_state;
	logic [1:0] pair;
	wait_departure(name);
	// Step from half a clock into the first bit to mid-bit
	repeat (CLKS_PER_BIT / 2 - 1) @(negedge tb_clk);
	prev = 1'b1;
	foreach (exp_bits[i]) begin
		pair      = {dplus, dminus};
		exp_state = exp_bits[i] ? prev : ~prev;
		compare_bit(name, exp_bits[i], pair[1] == prev);
		compare_line(name, {exp_state, ~exp_state}, pair);
		compare_bit({name, " tx_active"}, 1'b1, tx_active);
		prev = pair[1];
		next_sample(busy_start && (i == BUSY_PULSE_BIT));
	end
	for (int k = 0; k < EOP_SE0_BITS; k++) begin
		compare_line({name, " eop"}, 2'b00, {dplus, dminus});
		next_sample(1'b0);
	end
	compare_line({name, " final J"}, 2'b10, {dplus, dminus});
	compare_bit({name, " final J tx_active"}, 1'b1, tx_active);
endtask

`endif

// ==== sim/tb_usb_tx.sv ====
`timescale 1ns/1ps

// Testbench for the USB full-speed transmitter
// Runs a table of packets, decodes D+/D- mid-bit and checks against the model
// tx_data is served from the payload array, one byte per data_get pulse
// Stops at the first mismatch
module tb_usb_tx;
	import usb_tx_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int BUSY_PULSE_BIT = 10;
	localparam int PAT_ONES = 0;
	localparam int PAT_7E = 1;
	localparam int PAT_3F = 2;
	localparam int PAT_LFSR = 3;

	logic                 tb_clk;
	logic                 rst_n;
	logic                 tx_start;
	logic [PKT_SEL_W-1:0] tx_packet;
	logic [OCC_W-1:0]     buffer_occupancy;
	logic [7:0]           tx_data;
	logic                 data_get;
	logic                 tx_active;
	logic                 dplus;
	logic                 dminus;

	// Stimulus table, one entry per row in each queue
	string                row_name [$];
	logic [PKT_SEL_W-1:0] row_pkt [$];
	int                   row_len [$];
	int                   row_pat [$];
	bit                   row_busy [$];
	bit                   table_ready;

	int get_cnt;
	int get_base;

	usb_tx DUT (
		.tb_clk           (tb_clk),
		.rst_n            (rst_n),
		.tx_start         (tx_start),
		.tx_packet        (tx_packet),
		.buffer_occupancy (buffer_occupancy),
		.tx_data          (tx_data),
		.data_get         (data_get),
		.tx_active        (tx_active),
		.dplus            (dplus),
		.dminus           (dminus)
	);

	initial begin
		tb_clk = 1'b0;
		forever #20 tb_clk = ~tb_clk;
	end

	// **************************************************
	// Failure reporting and compare tasks
	// **************************************************
	task automatic stop_run();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic report_failure(input string what);
		$display("Error: %s", what);
		stop_run();
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_count(input string name, input logic [OCC_W-1:0] exp,
		input logic [OCC_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_line(input string name, input logic [1:0] exp,
		input logic [1:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	`include "tb_usb_tx_model.svh"

	// data_get counted mid-cycle, next byte presented on the following edge
	initial begin
		get_cnt = 0;
		forever begin
			@(negedge tb_clk);
			if (data_get === 1'b1)
				get_cnt++;
		end
	end

	initial begin
		int fetch_idx;
		tx_data = 8'h00;
		forever begin
			@(posedge tb_clk);
			fetch_idx = get_cnt - get_base;
			if (fetch_idx >= 0 && fetch_idx < MAX_PAYLOAD)
				tx_data <= payload[fetch_idx];
			else
				tx_data <= 8'h00;
		end
	end

	function automatic int row_clocks(input logic [PKT_SEL_W-1:0] pkt, input int len);
		int raw;
		raw = SYNC_BITS + 8;
		if (pkt == PKT_DATA0)
			raw = raw + len * 8 + CRC_W;
		return (raw + raw / STUFF_LIMIT + EOP_SE0_BITS + 8) * CLKS_PER_BIT;
	endfunction

	initial begin
		int limit;
		wait (table_ready);
		limit = RESET_CYCLES + 400;
		foreach (row_len[r])
			limit = limit + row_clocks(row_pkt[r], row_len[r]);
		repeat (limit) @(posedge tb_clk);
		report_failure($sformatf("watchdog expired after %0d clocks", limit));
	end

	// **************************************************
	// Table and row sequencing
	// **************************************************
	task automatic add_row(input string name, input logic [PKT_SEL_W-1:0] pkt,
		input int len, input int pattern, input bit busy);
		row_name.push_back(name);
		row_pkt.push_back(pkt);
		row_len.push_back(len);
		row_pat.push_back(pattern);
		row_busy.push_back(busy);
	endtask

	task automatic load_table();
		add_row("ack", PKT_ACK, 0, PAT_ONES, 1'b0);
		add_row("nak", PKT_NAK, 0, PAT_ONES, 1'b0);
		add_row("stall", PKT_STALL, 0, PAT_ONES, 1'b0);
		add_row("data0_empty", PKT_DATA0, 0, PAT_ONES, 1'b0);
		add_row("data0_lfsr_1", PKT_DATA0, 1, PAT_LFSR, 1'b0);
		add_row("data0_lfsr_32", PKT_DATA0, 32, PAT_LFSR, 1'b0);
		add_row("data0_lfsr_64", PKT_DATA0, 64, PAT_LFSR, 1'b0);
		add_row("data0_ones_8", PKT_DATA0, 8, PAT_ONES, 1'b0);
		add_row("data0_7e_16", PKT_DATA0, 16, PAT_7E, 1'b0);
		add_row("data0_3f_16", PKT_DATA0, 16, PAT_3F, 1'b0);
		add_row("data0_busy_start", PKT_DATA0, 12, PAT_LFSR, 1'b1);
		add_row("nak_busy_start", PKT_NAK, 0, PAT_ONES, 1'b1);
		add_row("ack_after_busy", PKT_ACK, 0, PAT_ONES, 1'b0);
	endtask

	task automatic fill_payload(input int pattern, input int len);
		for (int n = 0; n < len; n++) begin
			case (pattern)
				PAT_ONES: payload[n] = 8'hff;
				PAT_7E:   payload[n] = 8'h7e;
				PAT_3F:   payload[n] = 8'h3f;
				default:  payload[n] = lfsr_byte();
			endcase
		end
	endtask

	task automatic check_idle(input string name);
		compare_bit({name, " tx_active"}, 1'b0, tx_active);
		compare_bit({name, " data_get"}, 1'b0, data_get);
		compare_line({name, " lines"}, 2'b10, {dplus, dminus});
	endtask

	task automatic run_row(input int r);
		string name;
		int    len;
		int    fetch_exp;
		int    waited;
		name = row_name[r];
		len  = row_len[r];
		fill_payload(row_pat[r], len);
		build_expected(row_pkt[r], len);
		fetch_exp = (row_pkt[r] == PKT_DATA0) ? len : 0;
		get_base  = get_cnt;
		@(posedge tb_clk);
		tx_start         <= 1'b1;
		tx_packet        <= row_pkt[r];
		buffer_occupancy <= OCC_W'(len);
		@(posedge tb_clk);
		tx_start <= 1'b0;
		@(negedge tb_clk);
		compare_bit({name, " tx_active"}, 1'b1, tx_active);
		decode_packet(name, row_busy[r]);
		waited = 0;
		while (tx_active) begin
			@(negedge tb_clk);
			waited++;
			if (waited > 2 * CLKS_PER_BIT)
				report_failure({name, ": tx_active stayed high after the packet"});
		end
		compare_count({name, " data_get"}, OCC_W'(fetch_exp), OCC_W'(get_cnt - get_base));
		repeat (3) begin
			@(negedge tb_clk);
			check_idle({name, " after"});
		end
	endtask

	initial begin
		rst_n            = 1'b0;
		tx_start         = 1'b0;
		tx_packet        = PKT_ACK;
		buffer_occupancy = '0;
		get_base         = 0;
		lfsr_q           = 32'h2236;
		load_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) begin
			@(negedge tb_clk);
			check_idle("reset");
		end
		@(posedge tb_clk);
		rst_n <= 1'b1;
		repeat (4) begin
			@(negedge tb_clk);
			check_idle("post_reset");
		end
		foreach (row_name[r])
			run_row(r);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== hdl/usb_tx.sv ====
`timescale 1ns/1ps

// USB full-speed bulk endpoint transmitter, ACK, NAK, STALL and DATA0
// The first sync bit reaches the lines one clock after tx_active rises
// tx_data must show the next payload byte within a bit time of data_get
module usb_tx (
	input  logic                             tb_clk,
	input  logic                             rst_n,
	input  logic                             tx_start,
	input  logic [usb_tx_pkg::PKT_SEL_W-1:0] tx_packet,
	input  logic [usb_tx_pkg::OCC_W-1:0]     buffer_occupancy,
	input  logic [7:0]                       tx_data,
	output logic                             data_get,
	output logic                             tx_active,
	output logic                             dplus,
	output logic                             dminus
);

	logic       raw_bit;
	logic       bit_valid;
	logic       stuff_en;
	logic       bit_tick;
	logic       bit_taken;
	logic [1:0] fsm_sym;
	logic [1:0] line_sym;
	logic       line_bit;
	logic       crc_clear;
	logic       crc_feed;
	logic       crc_shift;
	logic       crc_bit;

	usb_tx_packet_fsm u_fsm (
		.tb_clk           (tb_clk),
		.rst_n            (rst_n),
		.tx_start         (tx_start),
		.tx_packet        (tx_packet),
		.buffer_occupancy (buffer_occupancy),
		.tx_data          (tx_data),
		.bit_taken        (bit_taken),
		.crc_bit          (crc_bit),
		.data_get         (data_get),
		.tx_active        (tx_active),
		.raw_bit          (raw_bit),
		.bit_valid        (bit_valid),
		.stuff_en         (stuff_en),
		.bit_tick         (bit_tick),
		.line_sym         (fsm_sym),
		.crc_clear        (crc_clear),
		.crc_feed         (crc_feed),
		.crc_shift        (crc_shift)
	);

	// Taken bits are the CRC strobe, a withheld bit is offered again
	usb_tx_crc16 u_crc (
		.tb_clk     (tb_clk),
		.rst_n      (rst_n),
		.crc_clear  (crc_clear),
		.bit_strobe (bit_taken),
		.crc_feed   (crc_feed),
		.crc_shift  (crc_shift),
		.data_bit   (raw_bit),
		.crc_bit    (crc_bit)
	);

	usb_tx_bit_stuffer u_stuff (
		.tb_clk    (tb_clk),
		.rst_n     (rst_n),
		.raw_bit   (raw_bit),
		.bit_valid (bit_valid),
		.stuff_en  (stuff_en),
		.bit_tick  (bit_tick),
		.sym_in    (fsm_sym),
		.bit_taken (bit_taken),
		.line_bit  (line_bit),
		.line_sym  (line_sym)
	);

	usb_tx_line_encoder u_line (
		.tb_clk   (tb_clk),
		.rst_n    (rst_n),
		.line_bit (line_bit),
		.bit_tick (bit_tick),
		.line_sym (line_sym),
		.dplus    (dplus),
		.dminus   (dminus)
	);

endmodule

// ==== hdl/usb_tx_line_encoder.sv ====
`timescale 1ns/1ps

// NRZI encoder and D+/D- driver
// Acts one clock after each bit_tick, when the stuffer output has settled
// J is dplus high and dminus low, SE0 drives both low
module usb_tx_line_encoder (
	input  logic       tb_clk,
	input  logic       rst_n,
	input  logic       line_bit,
	input  logic       bit_tick,
	input  logic [1:0] line_sym,
	output logic       dplus,
	output logic       dminus
);
	import usb_tx_pkg::*;

	logic tick_q;
	// Line state, high for J and low for K
	logic nrzi_q;
	logic nrzi_nxt;
	logic se0;

	assign se0 = (line_sym == SYM_SE0);

	always_comb begin
		case (line_sym)
			SYM_J:   nrzi_nxt = 1'b1;
			SYM_SE0: nrzi_nxt = nrzi_q;
			// Zero toggles the line, one holds it
			default: nrzi_nxt = line_bit ? nrzi_q : ~nrzi_q;
		endcase
	end

	always_ff @(posedge tb_clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_q <= 1'b0;
			nrzi_q <= 1'b1;
			dplus  <= 1'b1;
			dminus <= 1'b0;
		end else begin
			tick_q <= bit_tick;
			if (tick_q) begin
				nrzi_q <= nrzi_nxt;
				dplus  <= !se0 && nrzi_nxt;
				dminus <= !se0 && !nrzi_nxt;
			end
		end
	end

endmodule

// ==== hdl/usb_tx_bit_stuffer.sv ====
`timescale 1ns/1ps

// Bit stuffer between the sequencer and the line driver
// Ones are counted only while stuff_en is high, so a stuffed zero owed after
// the last CRC bit still goes out ahead of the EOP
// bit_taken is combinational and low for the bit time a zero is inserted
module usb_tx_bit_stuffer (
	input  logic       tb_clk,
	input  logic       rst_n,
	input  logic       raw_bit,
	input  logic       bit_valid,
	input  logic       stuff_en,
	input  logic       bit_tick,
	input  logic [1:0] sym_in,
	output logic       bit_taken,
	output logic       line_bit,
	output logic [1:0] line_sym
);
	import usb_tx_pkg::*;

	logic [ONES_W-1:0] ones_cnt;
	logic              offer;
	logic              stuff_now;

	assign offer     = bit_tick && bit_valid;
	assign stuff_now = (ones_cnt == ONES_W'(STUFF_LIMIT));
	assign bit_taken = offer && !stuff_now;

	always_ff @(posedge tb_clk or negedge rst_n) begin
		if (!rst_n) begin
			ones_cnt <= '0;
			line_bit <= 1'b1;
			line_sym <= SYM_J;
		end else if (offer) begin
			if (stuff_now) begin
				// Inserted zero, the offered bit waits one bit time
				line_bit <= 1'b0;
				line_sym <= SYM_DATA;
				ones_cnt <= '0;
			end else begin
				line_bit <= raw_bit;
				line_sym <= sym_in;
				if (stuff_en && raw_bit)
					ones_cnt <= ones_cnt + 1'b1;
				else
					ones_cnt <= '0;
			end
		end
	end

endmodule

// ==== hdl/usb_tx_crc16.sv ====
`timescale 1ns/1ps

// Serial CRC-16 for DATA0 payloads, data bits fed LSB first
// Only strobed bits count, so a repeated bit after stuffing is not fed twice
// While shifting, crc_bit is the complemented remainder, top bit first
module usb_tx_crc16 (
	input  logic tb_clk,
	input  logic rst_n,
	input  logic crc_clear,
	input  logic bit_strobe,
	input  logic crc_feed,
	input  logic crc_shift,
	input  logic data_bit,
	output logic crc_bit
);
	import usb_tx_pkg::*;

	logic [CRC_W-1:0] rem_q;
	logic             feedback;

	assign feedback = data_bit ^ rem_q[CRC_W-1];
	assign crc_bit  = ~rem_q[CRC_W-1];

	always_ff @(posedge tb_clk or negedge rst_n) begin
		if (!rst_n) begin
			rem_q <= CRC_INIT;
		end else if (crc_clear) begin
			rem_q <= CRC_INIT;
		end else if (bit_strobe && crc_feed) begin
			// Shift left, fold in the polynomial on a set feedback bit
			rem_q <= {rem_q[CRC_W-2:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
		end else if (bit_strobe && crc_shift) begin
			// Move the next remainder bit to the top
			rem_q <= {rem_q[CRC_W-2:0], 1'b1};
		end
	end

endmodule

// ==== hdl/usb_tx_packet_fsm.sv ====
`timescale 1ns/1ps

// Packet sequencer for sync, PID, DATA0 payload, CRC, EOP and the trailing J
// tx_start is taken only in idle, and sync bit 0 is offered in that same cycle
// data_get is combinational, tx_data is copied on the clock ending the pulse
// Payload length is latched at start and capped at MAX_PAYLOAD
// tx_active drops one clock after the last J bit time of the sequencer
module usb_tx_packet_fsm (
	input  logic                             tb_clk,
	input  logic                             rst_n,
	input  logic                             tx_start,
	input  logic [usb_tx_pkg::PKT_SEL_W-1:0] tx_packet,
	input  logic [usb_tx_pkg::OCC_W-1:0]     buffer_occupancy,
	input  logic [7:0]                       tx_data,
	input  logic                             bit_taken,
	input  logic                             crc_bit,
	output logic                             data_get,
	output logic                             tx_active,
	output logic                             raw_bit,
	output logic                             bit_valid,
	output logic                             stuff_en,
	output logic                             bit_tick,
	output logic [1:0]                       line_sym,
	output logic                             crc_clear,
	output logic                             crc_feed,
	output logic                             crc_shift
);
	import usb_tx_pkg::*;

	logic [STATE_W-1:0]   state_q;
	logic [STATE_W-1:0]   state_nxt;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [IDX_W-1:0]     idx_q;
	logic [IDX_W-1:0]     idx_nxt;
	logic [7:0]           shift_q;
	logic [PKT_SEL_W-1:0] pkt_q;
	logic [OCC_W-1:0]     bytes_q;
	logic [OCC_W-1:0]     occ_limited;
	logic [3:0]           pid_code;
	usb_pid_u             pid_byte;
	logic                 start_ok;
	logic                 byte_end;
	logic                 more_bytes;
	logic                 load_byte;
	logic                 shift_bit;

	assign start_ok   = (state_q == ST_IDLE) && tx_start;
	assign bit_valid  = (state_q != ST_IDLE) || tx_start;
	// Bit timer is held at zero in idle, so a start lands on a boundary
	assign bit_tick   = (bit_cnt == '0);
	assign crc_clear  = start_ok;
	assign byte_end   = (idx_q == IDX_W'(7));
	assign more_bytes = (bytes_q != '0);
	assign load_byte  = bit_taken && byte_end && more_bytes &&
		((state_q == ST_PID) || (state_q == ST_DATA));
	assign shift_bit  = bit_taken && ((state_q == ST_PID) || (state_q == ST_DATA));
	assign data_get   = load_byte;

	assign occ_limited = (buffer_occupancy > OCC_W'(MAX_PAYLOAD)) ?
		OCC_W'(MAX_PAYLOAD) : buffer_occupancy;

	always_comb begin
		case (tx_packet)
			PKT_ACK:   pid_code = PID_ACK;
			PKT_NAK:   pid_code = PID_NAK;
			PKT_STALL: pid_code = PID_STALL;
			default:   pid_code = PID_DATA0;
		endcase
		pid_byte.fields.pid   = pid_code;
		pid_byte.fields.check = ~pid_code;
	end

	// **************************************************
	// Bit offered to the stuffer
	// **************************************************
	always_comb begin
		raw_bit   = 1'b0;
		stuff_en  = 1'b0;
		line_sym  = SYM_DATA;
		crc_feed  = 1'b0;
		crc_shift = 1'b0;
		case (state_q)
			ST_SYNC: raw_bit = (idx_q == IDX_W'(SYNC_BITS - 1));
			ST_PID: begin
				raw_bit  = shift_q[0];
				stuff_en = 1'b1;
			end
			ST_DATA: begin
				raw_bit  = shift_q[0];
				stuff_en = 1'b1;
				crc_feed = 1'b1;
			end
			ST_CRC: begin
				raw_bit   = crc_bit;
				stuff_en  = 1'b1;
				crc_shift = 1'b1;
			end
			ST_EOP:  line_sym = SYM_SE0;
			ST_J:    line_sym = SYM_J;
			// Idle offers sync bit 0
			default: raw_bit = 1'b0;
		endcase
	end

	// **************************************************
	// Next state, advanced only on taken bits
	// **************************************************
	always_comb begin
		state_nxt = state_q;
		case (state_q)
			ST_IDLE: begin
				if (start_ok)
					state_nxt = ST_SYNC;
			end
			ST_SYNC: begin
				if (bit_taken && (idx_q == IDX_W'(SYNC_BITS - 1)))
					state_nxt = ST_PID;
			end
			ST_PID: begin
				if (bit_taken && byte_end) begin
					if (pkt_q != PKT_DATA0)
						state_nxt = ST_EOP;
					else
						state_nxt = more_bytes ? ST_DATA : ST_CRC;
				end
			end
			ST_DATA: begin
				if (bit_taken && byte_end && !more_bytes)
					state_nxt = ST_CRC;
			end
			ST_CRC: begin
				if (bit_taken && (idx_q == IDX_W'(CRC_W - 1)))
					state_nxt = ST_EOP;
			end
			ST_EOP: begin
				if (bit_taken && (idx_q == IDX_W'(EOP_SE0_BITS - 1)))
					state_nxt = ST_J;
			end
			// J bit, then one more bit time holding J
			ST_J: begin
				if (bit_taken && (idx_q == IDX_W'(1)))
					state_nxt = ST_IDLE;
			end
			default: state_nxt = ST_IDLE;
		endcase

		// Idle already sent sync bit 0, so SYNC starts at index 1
		idx_nxt = bit_taken ? idx_q + 1'b1 : idx_q;
		if (load_byte || ((state_nxt != state_q) && (state_q != ST_IDLE)))
			idx_nxt = '0;
	end

	always_ff @(posedge tb_clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= ST_IDLE;
			idx_q     <= '0;
			bit_cnt   <= '0;
			pkt_q     <= PKT_DATA0;
			bytes_q   <= '0;
			tx_active <= 1'b0;
		end else begin
			state_q   <= state_nxt;
			idx_q     <= idx_nxt;
			tx_active <= start_ok || (state_q != ST_IDLE);
			if (state_nxt == ST_IDLE)
				bit_cnt <= '0;
			else if (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1))
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;
			if (start_ok) begin
				pkt_q   <= tx_packet;
				bytes_q <= (tx_packet == PKT_DATA0) ? occ_limited : '0;
			end else if (load_byte) begin
				bytes_q <= bytes_q - 1'b1;
			end
		end
	end

	// PID or payload byte, shifted out LSB first
	always_ff @(posedge tb_clk) begin
		if (start_ok)
			shift_q <= pid_byte.raw;
		else if (load_byte)
			shift_q <= tx_data;
		else if (shift_bit)
			shift_q <= {1'b0, shift_q[7:1]};
	end

endmodule

// ==== hdl/usb_tx_pkg.sv ====
// Constants and the PID byte type shared by the USB full-speed transmitter
// Bit timing assumes a clock of CLKS_PER_BIT times the 12 Mb/s line rate
// Only DATA0 and the three handshakes are encoded
package usb_tx_pkg;

	// **************************************************
	// Line timing
	// **************************************************
	localparam int CLKS_PER_BIT = 8;
	localparam int BIT_CNT_W = 3;
	localparam int SYNC_BITS = 8;
	localparam int STUFF_LIMIT = 6;
	localparam int ONES_W = $clog2(STUFF_LIMIT + 1);
	localparam int EOP_SE0_BITS = 2;

	// Line symbol select, sequencer through stuffer to line driver
	localparam logic [1:0] SYM_DATA = 2'd0;
	localparam logic [1:0] SYM_SE0 = 2'd1;
	localparam logic [1:0] SYM_J = 2'd2;

	// **************************************************
	// Packets and payload
	// **************************************************
	localparam int PKT_SEL_W = 2;
	localparam logic [PKT_SEL_W-1:0] PKT_DATA0 = 2'd0;
	localparam logic [PKT_SEL_W-1:0] PKT_ACK = 2'd1;
	localparam logic [PKT_SEL_W-1:0] PKT_NAK = 2'd2;
	localparam logic [PKT_SEL_W-1:0] PKT_STALL = 2'd3;

	localparam logic [3:0] PID_DATA0 = 4'b0011;
	localparam logic [3:0] PID_ACK = 4'b0010;
	localparam logic [3:0] PID_NAK = 4'b1010;
	localparam logic [3:0] PID_STALL = 4'b1110;

	localparam int OCC_W = 7;
	localparam int MAX_PAYLOAD = 64;

	// Sequencer states
	localparam int STATE_W = 3;
	localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
	localparam logic [STATE_W-1:0] ST_SYNC = 3'd1;
	localparam logic [STATE_W-1:0] ST_PID = 3'd2;
	localparam logic [STATE_W-1:0] ST_DATA = 3'd3;
	localparam logic [STATE_W-1:0] ST_CRC = 3'd4;
	localparam logic [STATE_W-1:0] ST_EOP = 3'd5;
	localparam logic [STATE_W-1:0] ST_J = 3'd6;

	// **************************************************
	// CRC
	// **************************************************
	localparam int CRC_W = 16;
	localparam int IDX_W = $clog2(CRC_W);
	localparam logic [CRC_W-1:0] CRC_POLY = 16'h8005;
	localparam logic [CRC_W-1:0] CRC_INIT = 16'hffff;

	// PID byte, raw or split into PID and its complement check
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [3:0] check;
			logic [3:0] pid;
		} fields;
	} usb_pid_u;

endpackage
